/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_top
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
src/mem_cfg_pkg.sv
src/mem_if_pkg.sv
src/write_align.sv
src/dup_bank.sv
src/read_collect.sv
src/nr1w_dup_top.sv
sim/nr1w_chk.sv
sim/nr1w_scoreboard.sv
sim/tb_top.sv

/* sim/nr1w_chk.sv */
`timescale 1ns/1ps

module nr1w_chk (
  input logic                wr_clk,
  input logic                rst,
  input mem_if_pkg::wr_req_t wr_req,
  input mem_if_pkg::rd_req_t rd_req   [0:mem_cfg_pkg::NUMRDPT-1],
  input mem_if_pkg::rd_rsp_t rd_rsp   [0:mem_cfg_pkg::NUMRDPT-1],
  input mem_if_pkg::row_wr_t row_wr,
  input mem_if_pkg::rd_rsp_t bank_rsp [0:mem_cfg_pkg::NUMRDPT-1]
);

  localparam logic [mem_cfg_pkg::PHYWDTH-1:0] LANE0 = {mem_cfg_pkg::WIDTH{1'b1}};

  int                              fail_cnt = 0;
  logic [mem_cfg_pkg::PHYWDTH-1:0] lane_mask;

  always_comb begin
    lane_mask = LANE0 << (wr_req.adr.row.wsel * mem_cfg_pkg::WIDTH);  // Lane of this write.
  end

  a_row_write: assert property (@(posedge wr_clk) disable iff (rst)
    row_wr.write == $past(wr_req.write))
    else begin $error("Row write strobe does not follow the logical write"); fail_cnt++; end

  a_lane_mask: assert property (@(posedge wr_clk) disable iff (rst)
    wr_req.write |=> (row_wr.row_bw & ~$past(lane_mask)) == '0)
    else begin $error("row_bw has bits set outside the selected lane"); fail_cnt++; end

  for (genvar p = 0; p < mem_cfg_pkg::NUMRDPT; p++) begin : g_port
    a_bank_lat: assert property (@(posedge wr_clk) disable iff (rst)
      bank_rsp[p].vld == $past(rd_req[p].read, 3))
      else begin $error("Replica %0d result is not two edges after the address", p); fail_cnt++; end

    a_rsp_lat: assert property (@(posedge wr_clk) disable iff (rst)
      rd_rsp[p].vld == $past(rd_req[p].read, 4))
      else begin $error("Port %0d vld is not three edges after the read", p); fail_cnt++; end

    a_dout_hold: assert property (@(posedge wr_clk) disable iff (rst)
      !rd_rsp[p].vld |-> $stable(rd_rsp[p].dout))
      else begin $error("Port %0d dout changed without vld", p); fail_cnt++; end
  end

endmodule

bind nr1w_dup_top nr1w_chk chk0 (
  .wr_clk   (wr_clk),
  .rst      (rst),
  .wr_req   (wr_req),
  .rd_req   (rd_req),
  .rd_rsp   (rd_rsp),
  .row_wr   (row_wr),
  .bank_rsp (bank_rsp)
);

/* sim/nr1w_input.txt */
# Columns are wr adr bw din, then rd adr exp for ports 0, 1 and 2, all in hex.
# One line per cycle; an exp of x is not compared.
1 00 ffff 1111 0 00 x 0 00 x 0 00 x
1 01 ffff 2222 0 00 x 0 00 x 0 00 x
1 02 ffff 3333 0 00 x 0 00 x 0 00 x
1 03 ffff 4444 0 00 x 0 00 x 0 00 x
1 04 ffff 5555 1 00 1111 1 01 2222 1 02 3333
1 40 ffff a5a5 1 03 4444 1 03 4444 1 03 4444
1 41 ffff 5a5a 1 04 5555 1 00 1111 1 40 a5a5
1 01 00ff abcd 1 01 2222 1 00 1111 1 02 3333
0 00 0000 0000 1 01 22cd 1 01 22cd 1 41 5a5a
1 02 f0f0 0f0f 1 00 1111 1 03 4444 1 02 3333
0 00 0000 0000 1 02 0303 1 01 22cd 1 00 1111
0 00 0000 0000 0 00 x 0 00 x 0 00 x
0 00 0000 0000 0 00 x 0 00 x 0 00 x
1 ff ffff dead 1 40 a5a5 0 00 x 0 00 x
1 fc ffff beef 1 ff dead 0 00 x 1 41 5a5a
1 fd ffff cafe 1 fc beef 1 ff dead 0 00 x
1 fe ffff f00d 1 fd cafe 1 fc beef 1 ff dead
1 ff ff00 1200 1 fe f00d 1 ff dead 1 fd cafe
0 00 0000 0000 1 ff 12ad 1 fc beef 1 fe f00d
1 80 ffff 0001 1 ff 12ad 1 ff 12ad 1 ff 12ad
1 80 ffff 0002 1 80 0001 0 00 x 0 00 x
1 80 ffff 0003 1 80 0002 1 80 0002 1 80 0002
0 00 0000 0000 1 80 0003 0 00 x 1 80 0003
1 81 ffff 7777 0 00 x 0 00 x 0 00 x
1 81 000f 0009 1 81 7777 1 80 0003 0 00 x
1 81 f000 1000 1 81 7779 0 00 x 1 81 7779
0 00 0000 0000 1 81 1779 1 81 1779 1 80 0003
1 c3 ffff 3c3c 0 00 x 0 00 x 0 00 x
1 c2 ffff 2c2c 1 c3 3c3c 0 00 x 0 00 x
1 c1 ffff 1c1c 0 00 x 1 c2 2c2c 1 c3 3c3c
1 c0 ffff 0c0c 0 00 x 0 00 x 1 c1 1c1c
0 00 0000 0000 1 c0 0c0c 1 c1 1c1c 1 c2 2c2c
0 00 0000 0000 1 c3 3c3c 1 04 5555 1 40 a5a5
1 00 0000 ffff 1 00 1111 0 00 x 0 00 x
0 00 0000 0000 1 00 1111 1 00 1111 1 03 4444
0 00 0000 0000 0 00 x 0 00 x 0 00 x
0 00 0000 0000 0 00 x 0 00 x 0 00 x

/* sim/nr1w_scoreboard.sv */
`timescale 1ns/1ps

module nr1w_scoreboard (
  input  logic                            wr_clk,
  input  logic                            rst,
  input  mem_if_pkg::rd_req_t             rd_req   [0:mem_cfg_pkg::NUMRDPT-1],
  input  mem_if_pkg::rd_rsp_t             rd_rsp   [0:mem_cfg_pkg::NUMRDPT-1],
  input  logic [mem_cfg_pkg::NUMRDPT-1:0] exp_chk,
  input  logic [mem_cfg_pkg::WIDTH-1:0]   exp_data [0:mem_cfg_pkg::NUMRDPT-1],
  output int                              data_errs,
  output int                              timing_errs,
  output int                              pending
);

  localparam int RSP_LAT = 3;  // Edges from the request edge to the output register.

  typedef struct packed {
    int                            tag;   // Edge that samples the read.
    logic                          chk;
    logic [mem_cfg_pkg::WIDTH-1:0] data;
  } exp_t;

  exp_t                          exp_q     [0:mem_cfg_pkg::NUMRDPT-1][$];
  logic [mem_cfg_pkg::WIDTH-1:0] last_dout [0:mem_cfg_pkg::NUMRDPT-1];
  int                            cyc       = 0;
  int                            n_data    = 0;
  int                            n_timing  = 0;
  int                            n_pending = 0;

  assign data_errs   = n_data;
  assign timing_errs = n_timing;
  assign pending     = n_pending;

  // Negedge n sits in the cycle after edge n, so a request seen here is taken at edge n+1.
  always @(negedge wr_clk) begin
    exp_t head;
    int   n_pend;
    cyc    = cyc + 1;
    n_pend = 0;
    for (int p = 0; p < mem_cfg_pkg::NUMRDPT; p++) begin
      if (rst) begin
        exp_q[p].delete();
        if (rd_rsp[p].vld !== 1'b0) begin
          n_timing++;
          $display("Port %0d raised vld during reset", p);
        end
        if (rd_rsp[p].dout !== '0) begin
          n_data++;
          $display("Fail rd_rsp[%0d].dout: got %h expected %h in reset", p, rd_rsp[p].dout,
                   16'h0000);
        end
        last_dout[p] = '0;
      end else begin
        if (rd_rsp[p].vld) begin
          if (exp_q[p].size() == 0) begin
            n_timing++;
            $display("Port %0d raised vld at cycle %0d with no read pending", p, cyc);
          end else begin
            head = exp_q[p].pop_front();
            if (head.tag + RSP_LAT != cyc) begin
              n_timing++;
              $display("Port %0d vld came at cycle %0d for a read taken at edge %0d",
                       p, cyc, head.tag);
            end
            if (head.chk && rd_rsp[p].dout !== head.data) begin
              n_data++;
              $display("Fail rd_rsp[%0d].dout: got %h expected %h", p, rd_rsp[p].dout,
                       head.data);
            end
          end
          last_dout[p] = rd_rsp[p].dout;
        end else begin
          if (exp_q[p].size() != 0 && exp_q[p][0].tag + RSP_LAT <= cyc) begin
            head = exp_q[p].pop_front();
            n_timing++;
            $display("Port %0d never raised vld for the read taken at edge %0d", p, head.tag);
          end
          if (rd_rsp[p].dout !== last_dout[p]) begin
            n_data++;
            $display("Fail rd_rsp[%0d].dout: got %h expected %h while vld low", p,
                     rd_rsp[p].dout, last_dout[p]);
          end
        end
        if (rd_req[p].read) begin
          exp_q[p].push_back('{tag: cyc + 1, chk: exp_chk[p], data: exp_data[p]});
        end
      end
      n_pend += exp_q[p].size();
    end
    n_pending = n_pend;
  end

endmodule

/* sim/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  localparam int    CLK_PERIOD   = 100;
  localparam int    RST_CYCLES   = 16;
  localparam int    SLACK_CYCLES = 20;
  localparam string STIM_FILE    = "sim/nr1w_input.txt";

  logic                            wr_clk;
  logic                            rst;
  mem_if_pkg::wr_req_t             wr_req;
  mem_if_pkg::rd_req_t             rd_req   [0:mem_cfg_pkg::NUMRDPT-1];
  mem_if_pkg::rd_rsp_t             rd_rsp   [0:mem_cfg_pkg::NUMRDPT-1];
  logic [mem_cfg_pkg::NUMRDPT-1:0] exp_chk;
  logic [mem_cfg_pkg::WIDTH-1:0]   exp_data [0:mem_cfg_pkg::NUMRDPT-1];

  int    data_errs;
  int    timing_errs;
  int    pending;
  int    stim_errs   = 0;
  int    assert_errs = 0;
  bit    stim_loaded;
  string stim_lines [$];

  nr1w_dup_top dut0 (
    .wr_clk (wr_clk),
    .rst    (rst),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  nr1w_scoreboard u_scoreboard (
    .wr_clk      (wr_clk),
    .rst         (rst),
    .rd_req      (rd_req),
    .rd_rsp      (rd_rsp),
    .exp_chk     (exp_chk),
    .exp_data    (exp_data),
    .data_errs   (data_errs),
    .timing_errs (timing_errs),
    .pending     (pending)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(CLK_PERIOD / 2) wr_clk = ~wr_clk;
  end

  task automatic drive_idle();
    wr_req  = '0;
    exp_chk = '0;
    for (int p = 0; p < mem_cfg_pkg::NUMRDPT; p++) begin
      rd_req[p]   = '0;
      exp_data[p] = '0;
    end
  endtask

  // Keeps data lines only; lines starting with # are notes.
  task automatic load_stimulus();
    int    fd;
    string line;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      stim_errs++;
      $display("Could not open the stimulus file %s", STIM_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          stim_lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    stim_loaded = 1'b1;
  endtask

  task automatic drive_line(input string line);
    string       tok [0:12];
    int          n;
    logic [31:0] v;
    n = $sscanf(line, "%s %s %s %s %s %s %s %s %s %s %s %s %s", tok[0], tok[1], tok[2],
                tok[3], tok[4], tok[5], tok[6], tok[7], tok[8], tok[9], tok[10], tok[11],
                tok[12]);
    if (n != 13) begin
      stim_errs++;
      $display("A stimulus line has %0d fields instead of 13", n);
      drive_idle();
    end else begin
      v = tok[0].atohex();
      wr_req.write = v[0];
      v = tok[1].atohex();
      wr_req.adr.flat = v[mem_cfg_pkg::BITADDR-1:0];
      v = tok[2].atohex();
      wr_req.bw = v[mem_cfg_pkg::WIDTH-1:0];
      v = tok[3].atohex();
      wr_req.din = v[mem_cfg_pkg::WIDTH-1:0];
      for (int p = 0; p < mem_cfg_pkg::NUMRDPT; p++) begin
        v = tok[4 + 3 * p].atohex();
        rd_req[p].read = v[0];
        v = tok[5 + 3 * p].atohex();
        rd_req[p].adr.flat = v[mem_cfg_pkg::BITADDR-1:0];
        exp_chk[p] = (tok[6 + 3 * p] != "x");  // An x entry is not compared.
        v = tok[6 + 3 * p].atohex();
        exp_data[p] = v[mem_cfg_pkg::WIDTH-1:0];
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    drive_idle();
    load_stimulus();
    repeat (RST_CYCLES) @(posedge wr_clk);
    #1;
    rst = 1'b0;
    foreach (stim_lines[i]) begin
      drive_line(stim_lines[i]);
      @(posedge wr_clk);
      #1;
    end
    drive_idle();
    do begin
      @(posedge wr_clk);
    end while (pending != 0);  // Drain reads still in flight.
    assert_errs = dut0.chk0.fail_cnt;
    $display("Errors: data %0d, timing %0d, assertion %0d, stimulus %0d",
             data_errs, timing_errs, assert_errs, stim_errs);
    if (data_errs + timing_errs + assert_errs + stim_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    wait (stim_loaded);
    #((RST_CYCLES + stim_lines.size() + SLACK_CYCLES) * CLK_PERIOD);
    $display("Timeout because the run did not end within %0d cycles",
             RST_CYCLES + stim_lines.size() + SLACK_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* src/dup_bank.sv */
`timescale 1ns/1ps

module dup_bank (
  input  logic                wr_clk,
  input  logic                rst,
  input  mem_if_pkg::row_wr_t row_wr,
  input  mem_if_pkg::rd_req_t rd_req,
  output mem_if_pkg::rd_rsp_t bank_rsp
);

  // Replica storage, one physical row per entry.
  logic [mem_cfg_pkg::PHYWDTH-1:0] mem_array [0:mem_cfg_pkg::NUMSROW-1];

  logic                  req_vld_q;
  mem_if_pkg::mem_addr_u req_adr_q;

  logic [mem_cfg_pkg::ROWSTGS-1:0] vld_pipe;
  logic [mem_cfg_pkg::PHYWDTH-1:0] row_pipe  [0:mem_cfg_pkg::ROWSTGS-1];
  logic [mem_cfg_pkg::BITWRDS-1:0] wsel_pipe [0:mem_cfg_pkg::ROWSTGS-1];

  logic                          rsp_vld_q;
  logic [mem_cfg_pkg::WIDTH-1:0] rsp_dout_q;

  // Masked row write; unmasked bits keep their value.
  always_ff @(posedge wr_clk) begin
    if (row_wr.write) begin
      for (int i = 0; i < mem_cfg_pkg::PHYWDTH; i++) begin
        if (row_wr.row_bw[i]) begin
          mem_array[row_wr.srow][i] <= row_wr.row_din[i];
        end
      end
    end
  end

  // Address register.
  always_ff @(posedge wr_clk) begin
    if (rst) begin
      req_vld_q <= 1'b0;
    end else begin
      req_vld_q <= rd_req.read;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (rd_req.read) begin
      req_adr_q <= rd_req.adr;
    end
  end

  // Valid bit travels alongside the row data.
  always_ff @(posedge wr_clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= req_vld_q;
      for (int s = 1; s < mem_cfg_pkg::ROWSTGS; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  // The array read lands on the edge after the address register, so a write
  // on that same edge is not seen yet.
  always_ff @(posedge wr_clk) begin
    if (req_vld_q) begin
      row_pipe[0]  <= mem_array[req_adr_q.row.srow];
      wsel_pipe[0] <= req_adr_q.row.wsel;  // Lane select follows its row.
    end
    for (int s = 1; s < mem_cfg_pkg::ROWSTGS; s++) begin
      row_pipe[s]  <= row_pipe[s-1];
      wsel_pipe[s] <= wsel_pipe[s-1];
    end
  end

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= vld_pipe[mem_cfg_pkg::ROWSTGS-1];
    end
  end

  // Lane extraction at the last stage.
  always_ff @(posedge wr_clk) begin
    if (vld_pipe[mem_cfg_pkg::ROWSTGS-1]) begin
      rsp_dout_q <= row_pipe[mem_cfg_pkg::ROWSTGS-1][
        wsel_pipe[mem_cfg_pkg::ROWSTGS-1]*mem_cfg_pkg::WIDTH +: mem_cfg_pkg::WIDTH];
    end
  end

  assign bank_rsp.vld  = rsp_vld_q;
  assign bank_rsp.dout = rsp_dout_q;

endmodule

/* src/mem_cfg_pkg.sv */
package mem_cfg_pkg;

  // Logical word geometry.
  localparam int WIDTH   = 16;            // Bits per logical word.
  localparam int NUMADDR = 256;           // Logical words in the memory.
  localparam int BITADDR = $clog2(NUMADDR);

  // Read ports, each served by its own replica.
  localparam int NUMRDPT = 3;

  // Physical row packing.
  localparam int NUMWRDS = 4;             // Logical words packed into one row.
  localparam int BITWRDS = $clog2(NUMWRDS);
  localparam int NUMSROW = NUMADDR / NUMWRDS;
  localparam int BITSROW = $clog2(NUMSROW);
  localparam int PHYWDTH = NUMWRDS * WIDTH;

  // Read latency inside a replica, counted after the address register.
  localparam int SRAM_DELAY = 2;
  localparam int ROWSTGS    = SRAM_DELAY - 1; // Row stages ahead of the lane select.

  // Port to port latency of a read, including the output register.
  localparam int RD_LATENCY = SRAM_DELAY + 1;

endpackage

/* src/mem_if_pkg.sv */
package mem_if_pkg;

  // Row view of a logical address: the upper bits pick the row, the lower bits the lane.
  typedef struct packed {
    logic [mem_cfg_pkg::BITSROW-1:0] srow;
    logic [mem_cfg_pkg::BITWRDS-1:0] wsel;
  } mem_row_adr_t;

  // Ports see the flat address, the replicas decode the row view.
  typedef union packed {
    logic [mem_cfg_pkg::BITADDR-1:0] flat;
    mem_row_adr_t                    row;
  } mem_addr_u;

  // Logical write port.
  typedef struct packed {
    logic                          write;
    mem_addr_u                     adr;
    logic [mem_cfg_pkg::WIDTH-1:0] bw;    // Per-bit write mask.
    logic [mem_cfg_pkg::WIDTH-1:0] din;
  } wr_req_t;

  // Physical row write, shared by all replicas.
  typedef struct packed {
    logic                            write;
    logic [mem_cfg_pkg::BITSROW-1:0] srow;
    logic [mem_cfg_pkg::PHYWDTH-1:0] row_bw;
    logic [mem_cfg_pkg::PHYWDTH-1:0] row_din;
  } row_wr_t;

  // Read request of one port.
  typedef struct packed {
    logic      read;
    mem_addr_u adr;
  } rd_req_t;

  // Read response of one port.
  typedef struct packed {
    logic                          vld;
    logic [mem_cfg_pkg::WIDTH-1:0] dout;
  } rd_rsp_t;

endpackage

/* src/nr1w_dup_top.sv */
`timescale 1ns/1ps

module nr1w_dup_top (
  input  logic                wr_clk,
  input  logic                rst,
  input  mem_if_pkg::wr_req_t wr_req,
  input  mem_if_pkg::rd_req_t rd_req [0:mem_cfg_pkg::NUMRDPT-1],
  output mem_if_pkg::rd_rsp_t rd_rsp [0:mem_cfg_pkg::NUMRDPT-1]
);

  mem_if_pkg::row_wr_t row_wr;                            // Same row write for every replica.
  mem_if_pkg::rd_rsp_t bank_rsp [0:mem_cfg_pkg::NUMRDPT-1];

  write_align u_write_align (
    .wr_clk (wr_clk),
    .rst    (rst),
    .wr_req (wr_req),
    .row_wr (row_wr)
  );

  // One full copy of the memory per read port.
  for (genvar p = 0; p < mem_cfg_pkg::NUMRDPT; p++) begin : g_bank
    dup_bank u_dup_bank (
      .wr_clk   (wr_clk),
      .rst      (rst),
      .row_wr   (row_wr),
      .rd_req   (rd_req[p]),
      .bank_rsp (bank_rsp[p])
    );
  end

  read_collect u_read_collect (
    .wr_clk   (wr_clk),
    .rst      (rst),
    .bank_rsp (bank_rsp),
    .rd_rsp   (rd_rsp)
  );

endmodule

/* src/read_collect.sv */
`timescale 1ns/1ps

module read_collect (
  input  logic                wr_clk,
  input  logic                rst,
  input  mem_if_pkg::rd_rsp_t bank_rsp [0:mem_cfg_pkg::NUMRDPT-1],
  output mem_if_pkg::rd_rsp_t rd_rsp   [0:mem_cfg_pkg::NUMRDPT-1]
);

  logic [mem_cfg_pkg::NUMRDPT-1:0] vld_q;
  logic [mem_cfg_pkg::WIDTH-1:0]   dout_q [0:mem_cfg_pkg::NUMRDPT-1];

  // One output register per port, each fed by its own replica.
  for (genvar p = 0; p < mem_cfg_pkg::NUMRDPT; p++) begin : g_port

    always_ff @(posedge wr_clk) begin
      if (rst) begin
        vld_q[p] <= 1'b0;
      end else begin
        vld_q[p] <= bank_rsp[p].vld;  // Single cycle pulse per read.
      end
    end

    // Data is cleared by reset and otherwise holds until the next result.
    always_ff @(posedge wr_clk) begin
      if (rst) begin
        dout_q[p] <= '0;
      end else if (bank_rsp[p].vld) begin
        dout_q[p] <= bank_rsp[p].dout;
      end
    end

    assign rd_rsp[p].vld  = vld_q[p];
    assign rd_rsp[p].dout = dout_q[p];

  end

endmodule

/* src/write_align.sv */
`timescale 1ns/1ps

module write_align (
  input  logic                wr_clk,
  input  logic                rst,
  input  mem_if_pkg::wr_req_t wr_req,
  output mem_if_pkg::row_wr_t row_wr
);

  logic [mem_cfg_pkg::PHYWDTH-1:0] lane_bw;
  logic [mem_cfg_pkg::PHYWDTH-1:0] lane_din;

  logic                            write_q;
  logic [mem_cfg_pkg::BITSROW-1:0] srow_q;
  logic [mem_cfg_pkg::PHYWDTH-1:0] row_bw_q;
  logic [mem_cfg_pkg::PHYWDTH-1:0] row_din_q;

  // Steer the word into its lane of the row.
  // Every other lane gets a zero mask, so its bits keep their stored value
  // and no read-modify-write of the row is needed.
  always_comb begin
    lane_bw  = '0;
    lane_din = '0;
    lane_bw[wr_req.adr.row.wsel*mem_cfg_pkg::WIDTH +: mem_cfg_pkg::WIDTH]  = wr_req.bw;
    lane_din[wr_req.adr.row.wsel*mem_cfg_pkg::WIDTH +: mem_cfg_pkg::WIDTH] = wr_req.din;
  end

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      write_q <= 1'b0;
    end else begin
      write_q <= wr_req.write;                // Strobe reaches the replicas one edge later.
    end
  end

  // Row, mask and data only load with a write.
  always_ff @(posedge wr_clk) begin
    if (wr_req.write) begin
      srow_q    <= wr_req.adr.row.srow;
      row_bw_q  <= lane_bw;
      row_din_q <= lane_din;
    end
  end

  assign row_wr.write   = write_q;
  assign row_wr.srow    = srow_q;
  assign row_wr.row_bw  = row_bw_q;
  assign row_wr.row_din = row_din_q;

endmodule
